// ==== files.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_core.sv
tests/clk_gen.sv
tests/tb_mips_core.sv

// ==== hdl/decode_stage.sv ====
//--------------------------------------------------------------------------
// decode register, control decode, operand forwarding, branch resolution
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module decode_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               stall,
    input  isa_pkg::instr_t    fetch_instr,
    input  isa_pkg::word_t     fetch_pc,
    input  logic               fwd_rs,
    input  logic               fwd_rt,
    input  isa_pkg::word_t     mem_fwd_data,
    input  pipe_pkg::wb_port_t wb,
    output isa_pkg::reg_addr_t rs,
    output isa_pkg::reg_addr_t rt,
    output isa_pkg::opcode_e   op,
    output logic               branch_taken,
    output isa_pkg::word_t     branch_target,
    output pipe_pkg::id_ex_t   id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t instr_q;
    word_t  pc_q;
    ctrl_t  ctrl;
    word_t  rf_rs_data;
    word_t  rf_rt_data;
    word_t  rs_val;
    word_t  rt_val;
    word_t  imm;
    logic   equal;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            instr_q <= NOP_WORD;
        else if (stall)
            instr_q <= instr_q;
        else if (branch_taken)
            instr_q <= NOP_WORD;       // kill the slot after a taken branch
        else
            instr_q <= fetch_instr;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            pc_q <= fetch_pc;
    end

    always_comb
    begin
        ctrl = '0;
        case (instr_q.opcode)
            R_TYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.dest_rd   = 1'b1;
                ctrl.alu_op    = ALU_CLS_FUNCT;
            end
            ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            SW:
            begin
                ctrl.alu_src_imm = 1'b1;   // base + offset
                ctrl.mem_write   = 1'b1;
            end
            BEQ, BNE:
            begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_CLS_SUB;
            end
            default: ctrl = '0;            // unsupported opcode acts as a nop
        endcase
    end

    reg_file u_rf (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs        (instr_q.rs),
        .rt        (instr_q.rt),
        .rs_data   (rf_rs_data),
        .rt_data   (rf_rt_data),
        .wb        (wb)
    );

    assign rs  = instr_q.rs;
    assign rt  = instr_q.rt;
    assign op  = instr_q.opcode;
    assign imm = {{16{instr_q.low.imm[15]}}, instr_q.low.imm};

    assign rs_val = fwd_rs ? mem_fwd_data : rf_rs_data;    // newer result from memory
    assign rt_val = fwd_rt ? mem_fwd_data : rf_rt_data;

    // operands are only valid once the hazard has cleared
    assign equal         = (rs_val == rt_val);
    assign branch_taken  = ctrl.branch && !stall &&
                           ((instr_q.opcode == BEQ) ? equal : !equal);
    assign branch_target = pc_q + 32'd4 + {imm[29:0], 2'b00};

    assign id_ex = '{ctrl:   ctrl,
                     rs_val: rs_val,
                     rt_val: rt_val,
                     imm:    imm,
                     dest:   ctrl.dest_rd ? instr_q.low.r.rd : instr_q.rt,
                     funct:  instr_q.low.r.funct};

endmodule

// ==== hdl/execute_stage.sv ====
//--------------------------------------------------------------------------
// execute register, ALU control and ALU
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module execute_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               stall,
    input  pipe_pkg::id_ex_t   id_ex,
    output isa_pkg::reg_addr_t ex_dest,
    output pipe_pkg::ctrl_t    ex_ctrl,
    output pipe_pkg::ex_mem_t  ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ctrl_t     ctrl_q;
    word_t     a_q;
    word_t     b_q;
    word_t     imm_q;
    reg_addr_t dest_q;
    funct_e    funct_q;
    alu_op_e   alu_op;
    word_t     alu_b;
    word_t     alu_y;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
            ctrl_q <= '0;              // bubble while decode holds
        else
            ctrl_q <= id_ex.ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        a_q     <= id_ex.rs_val;
        b_q     <= id_ex.rt_val;
        imm_q   <= id_ex.imm;
        dest_q  <= id_ex.dest;
        funct_q <= id_ex.funct;
    end

    always_comb
    begin
        alu_op = ALU_ADD;
        case (ctrl_q.alu_op)
            ALU_CLS_SUB: alu_op = ALU_SUB;
            ALU_CLS_FUNCT:
            begin
                case (funct_q)
                    SUB:     alu_op = ALU_SUB;
                    AND:     alu_op = ALU_AND;
                    OR:      alu_op = ALU_OR;
                    SLT:     alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;     // addi, lw, sw address
        endcase
    end

    assign alu_b = ctrl_q.alu_src_imm ? imm_q : b_q;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: alu_y = a_q - alu_b;
            ALU_AND: alu_y = a_q & alu_b;
            ALU_OR:  alu_y = a_q | alu_b;
            ALU_SLT: alu_y = ($signed(a_q) < $signed(alu_b)) ? 32'd1 : 32'd0;
            default: alu_y = a_q + alu_b;
        endcase
    end

    assign ex_dest = dest_q;
    assign ex_ctrl = ctrl_q;
    assign ex_mem  = '{ctrl: ctrl_q, alu_result: alu_y, store_data: b_q, dest: dest_q};

endmodule

// ==== hdl/fetch_stage.sv ====
//--------------------------------------------------------------------------
// program counter: sequential, branch and stall updates
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_stage #(
    parameter isa_pkg::word_t RESET_PC = '0
) (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           stall,
    input  logic           branch_taken,
    input  isa_pkg::word_t branch_target,
    output isa_pkg::word_t pc
);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= RESET_PC;
        else if (stall)
            pc <= pc;                  // decode waiting on a hazard
        else if (branch_taken)
            pc <= branch_target;       // resolved in decode
        else
            pc <= pc + 32'd4;
    end

endmodule

// ==== hdl/hazard_unit.sv ====
//--------------------------------------------------------------------------
// read-after-write detection: stall level and memory forward selects
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::reg_addr_t rs,
    input  isa_pkg::reg_addr_t rt,
    input  isa_pkg::opcode_e   dec_op,
    input  pipe_pkg::ctrl_t    ex_ctrl,
    input  isa_pkg::reg_addr_t ex_dest,
    input  pipe_pkg::ctrl_t    mem_ctrl,
    input  isa_pkg::reg_addr_t mem_dest,
    output logic               stall,
    output logic               fwd_rs,
    output logic               fwd_rt
);
    import isa_pkg::*;

    logic uses_rt;
    logic rs_live;
    logic rt_live;
    logic ex_rs, ex_rt;
    logic load_rs, load_rt;
    logic alu_rs, alu_rt;

    // addi and lw take rt as their destination, not as a source
    assign uses_rt = (dec_op == R_TYPE) || (dec_op == BEQ) ||
                     (dec_op == BNE)    || (dec_op == SW);
    assign rs_live = (rs != '0);
    assign rt_live = uses_rt && (rt != '0);

    assign ex_rs   = ex_ctrl.reg_write && (ex_dest == rs);      // result not ready yet
    assign ex_rt   = ex_ctrl.reg_write && (ex_dest == rt);
    assign load_rs = mem_ctrl.mem_read && (mem_dest == rs);     // load data too late
    assign load_rt = mem_ctrl.mem_read && (mem_dest == rt);
    assign alu_rs  = mem_ctrl.reg_write && !mem_ctrl.mem_read && (mem_dest == rs);
    assign alu_rt  = mem_ctrl.reg_write && !mem_ctrl.mem_read && (mem_dest == rt);

    assign stall  = (rs_live && (ex_rs || load_rs)) ||
                    (rt_live && (ex_rt || load_rt));
    assign fwd_rs = rs_live && alu_rs;
    assign fwd_rt = rt_live && alu_rt;

endmodule

// ==== hdl/isa_pkg.sv ====
//--------------------------------------------------------------------------
// instruction-set encoding for the MIPS-style subset: word and register
// types, opcode and funct enums, instruction layout and the bubble word
//--------------------------------------------------------------------------
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0]
    {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b,
        BEQ    = 6'h04,
        BNE    = 6'h05
    } opcode_e;

    typedef enum logic [5:0]
    {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    // lower 16 bits of an R-type word
    typedef struct packed {
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_low_t;

    // I-type reuses the same bits as the immediate
    typedef union packed {
        r_low_t      r;
        logic [15:0] imm;
    } low_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        low_t      low;
    } instr_t;

    localparam instr_t NOP_WORD = '0;  // add $0,$0,$0, writes nothing

endpackage

// ==== hdl/memory_stage.sv ====
//--------------------------------------------------------------------------
// memory register, data memory, write-back register and result select
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  pipe_pkg::ex_mem_t  ex_mem,
    output pipe_pkg::ctrl_t    mem_ctrl,
    output isa_pkg::reg_addr_t mem_dest,
    output isa_pkg::word_t     mem_fwd_data,
    output pipe_pkg::wb_port_t wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    ctrl_t            ctrl_q;
    word_t            alu_q;
    word_t            sdata_q;
    reg_addr_t        dest_q;
    word_t            dmem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    word_t            load_data;
    logic             wb_we_q;
    reg_addr_t        wb_addr_q;
    word_t            wb_data_q;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ctrl_q <= '0;
        else
            ctrl_q <= ex_mem.ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        alu_q   <= ex_mem.alu_result;
        sdata_q <= ex_mem.store_data;
        dest_q  <= ex_mem.dest;
    end

    assign idx       = alu_q[IDX_W+1:2];   // word index, byte offset dropped
    assign load_data = dmem[idx];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (ctrl_q.mem_write)
            dmem[idx] <= sdata_q;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb_we_q <= 1'b0;
        else
            wb_we_q <= ctrl_q.reg_write && (dest_q != '0);   // $0 never written
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_addr_q <= dest_q;
        wb_data_q <= ctrl_q.mem_to_reg ? load_data : alu_q;
    end

    assign mem_ctrl     = ctrl_q;
    assign mem_dest     = dest_q;
    assign mem_fwd_data = alu_q;
    assign wb           = '{we: wb_we_q, addr: wb_addr_q, data: wb_data_q};

endmodule

// ==== hdl/mips_core.sv ====
//--------------------------------------------------------------------------
// five-stage pipelined core, stage and hazard unit hookup
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module mips_core #(
    parameter isa_pkg::word_t RESET_PC   = '0,
    parameter int             DMEM_WORDS = 256
) (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    output isa_pkg::word_t    imem_addr,  // byte address
    input  isa_pkg::instr_t   imem_data,
    output pipe_pkg::wb_port_t wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    reg_addr_t rs;
    reg_addr_t rt;
    opcode_e   dec_op;
    logic      fwd_rs;
    logic      fwd_rt;
    id_ex_t    id_ex;
    reg_addr_t ex_dest;
    ctrl_t     ex_ctrl;
    ex_mem_t   ex_mem;
    ctrl_t     mem_ctrl;
    reg_addr_t mem_dest;
    word_t     mem_fwd_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (imem_addr)
    );

    decode_stage u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .fetch_instr   (imem_data),
        .fetch_pc      (imem_addr),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .mem_fwd_data  (mem_fwd_data),
        .wb            (wb),
        .rs            (rs),
        .rt            (rt),
        .op            (dec_op),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (id_ex)
    );

    hazard_unit u_hazard (
        .rs       (rs),
        .rt       (rt),
        .dec_op   (dec_op),
        .ex_ctrl  (ex_ctrl),
        .ex_dest  (ex_dest),
        .mem_ctrl (mem_ctrl),
        .mem_dest (mem_dest),
        .stall    (stall),
        .fwd_rs   (fwd_rs),
        .fwd_rt   (fwd_rt)
    );

    execute_stage u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .id_ex     (id_ex),
        .ex_dest   (ex_dest),
        .ex_ctrl   (ex_ctrl),
        .ex_mem    (ex_mem)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .ex_mem       (ex_mem),
        .mem_ctrl     (mem_ctrl),
        .mem_dest     (mem_dest),
        .mem_fwd_data (mem_fwd_data),
        .wb           (wb)
    );

endmodule

// ==== hdl/pipe_pkg.sv ====
//--------------------------------------------------------------------------
// pipeline types: control bundle, ALU operations, stage registers
// and the register-file write port
//--------------------------------------------------------------------------
package pipe_pkg;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // coarse ALU class from the main decoder, refined by funct in execute
    typedef enum logic [1:0]
    {
        ALU_CLS_ADD,
        ALU_CLS_SUB,
        ALU_CLS_FUNCT
    } alu_cls_e;

    typedef struct packed {
        logic     reg_write;
        logic     dest_rd;      // write rd, else rt
        logic     alu_src_imm;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     branch;
        alu_cls_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::word_t     rs_val;
        isa_pkg::word_t     rt_val;
        isa_pkg::word_t     imm;
        isa_pkg::reg_addr_t dest;
        isa_pkg::funct_e    funct;
    } id_ex_t;

    typedef struct packed {
        ctrl_t              ctrl;
        isa_pkg::word_t     alu_result;
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t     data;
    } wb_port_t;

endpackage

// ==== hdl/reg_file.sv ====
//--------------------------------------------------------------------------
// 32 x 32-bit register file, two reads, one write with write-through
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module reg_file (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  isa_pkg::reg_addr_t rs,
    input  isa_pkg::reg_addr_t rt,
    output isa_pkg::word_t     rs_data,
    output isa_pkg::word_t     rt_data,
    input  pipe_pkg::wb_port_t wb
);
    import isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.we && (wb.addr != '0))
            regs[wb.addr] <= wb.data;
    end

    // $0 is hardwired, a same-cycle write is passed through
    assign rs_data = (rs == '0)                      ? '0 :
                     (wb.we && (wb.addr == rs))      ? wb.data : regs[rs];
    assign rt_data = (rt == '0)                      ? '0 :
                     (wb.we && (wb.addr == rt))      ? wb.data : regs[rt];

endmodule

// ==== tests/clk_gen.sv ====
//--------------------------------------------------------------------------
// free-running testbench clock
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== tests/tb_mips_core.sv ====
//--------------------------------------------------------------------------
// mips_core testbench with program table, instruction memory model,
// expected write-back table, check tasks and cycle limit
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mips_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int    PROG_LEN       = 33;
    localparam int    NUM_EXP        = 23;
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 3 + RESET_CYCLES + 32;
    localparam word_t RESET_PC       = 32'h0000_0000;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
    } wb_exp_t;

    logic     SYS_clk;
    logic     SYS_reset;
    word_t    imem_addr;
    instr_t   imem_data;
    wb_port_t wb;

    instr_t  prog [PROG_LEN];
    wb_exp_t exp_tab [NUM_EXP];
    int      row;
    int      cycle_count = 0;

    clk_gen #(.PERIOD_NS(8.0)) u_clk (.clk(SYS_clk));

    mips_core #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (256)
    ) DUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    function automatic instr_t r_type_word(funct_e fn, reg_addr_t rd, reg_addr_t rs,
                                           reg_addr_t rt);
        return instr_t'({6'h00, rs, rt, rd, 5'd0, fn});
    endfunction

    // operands in assembly order with rt before rs
    function automatic instr_t i_type_word(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                           logic [15:0] imm);
        return instr_t'({op, rs, rt, imm});
    endfunction

    // word-addressed program that reads a nop past the end or at an unknown address
    function automatic instr_t fetch_word(word_t addr);
        if (addr[31:2] < PROG_LEN)
            return prog[addr[31:2]];
        else
            return NOP_WORD;
    endfunction

    assign imem_data = fetch_word(imem_addr);    // combinational instruction memory

    always @(posedge SYS_clk)
        cycle_count <= cycle_count + 1;

    task automatic load_program();
        prog[0]  = i_type_word(ADDI, 5'd1, 5'd0, 16'd7);
        prog[1]  = i_type_word(ADDI, 5'd2, 5'd0, 16'hfffd);    // -3
        prog[2]  = r_type_word(ADD, 5'd3, 5'd1, 5'd2);
        prog[3]  = r_type_word(SUB, 5'd4, 5'd1, 5'd2);
        prog[4]  = r_type_word(AND, 5'd5, 5'd1, 5'd2);
        prog[5]  = r_type_word(OR, 5'd6, 5'd1, 5'd2);
        prog[6]  = r_type_word(SLT, 5'd7, 5'd2, 5'd1);         // signed compare -3 < 7
        prog[7]  = r_type_word(SLT, 5'd8, 5'd1, 5'd2);
        prog[8]  = i_type_word(ADDI, 5'd9, 5'd0, 16'd5);
        prog[9]  = r_type_word(ADD, 5'd10, 5'd9, 5'd9);        // dependent chain
        prog[10] = r_type_word(ADD, 5'd11, 5'd10, 5'd9);
        prog[11] = r_type_word(SUB, 5'd12, 5'd11, 5'd10);
        prog[12] = i_type_word(ADDI, 5'd13, 5'd0, 16'h0040);   // data base
        prog[13] = i_type_word(SW, 5'd11, 5'd13, 16'd0);
        prog[14] = i_type_word(SW, 5'd4, 5'd13, 16'd4);
        prog[15] = i_type_word(LW, 5'd14, 5'd13, 16'd0);
        prog[16] = r_type_word(ADD, 5'd15, 5'd14, 5'd1);       // load used in the next slot
        prog[17] = i_type_word(LW, 5'd16, 5'd13, 16'd4);
        prog[18] = i_type_word(ADDI, 5'd17, 5'd0, 16'd1);
        prog[19] = r_type_word(ADD, 5'd18, 5'd16, 5'd17);      // load used two later
        prog[20] = i_type_word(BEQ, 5'd2, 5'd1, 16'd2);        // not taken
        prog[21] = i_type_word(ADDI, 5'd19, 5'd0, 16'd19);
        prog[22] = i_type_word(BNE, 5'd12, 5'd9, 16'd2);       // not taken
        prog[23] = i_type_word(ADDI, 5'd20, 5'd0, 16'd20);
        prog[24] = i_type_word(BEQ, 5'd12, 5'd9, 16'd2);       // taken
        prog[25] = i_type_word(ADDI, 5'd21, 5'd0, 16'd21);     // squashed slot
        prog[26] = i_type_word(ADDI, 5'd22, 5'd0, 16'd22);     // jumped over
        prog[27] = i_type_word(ADDI, 5'd23, 5'd0, 16'd23);
        prog[28] = i_type_word(BNE, 5'd2, 5'd1, 16'd1);        // taken
        prog[29] = i_type_word(ADDI, 5'd24, 5'd0, 16'd24);     // squashed slot
        prog[30] = i_type_word(ADDI, 5'd25, 5'd0, 16'd25);
        prog[31] = i_type_word(ADDI, 5'd0, 5'd0, 16'd99);      // no write
        prog[32] = r_type_word(ADD, 5'd26, 5'd0, 5'd1);
    endtask

    // write-backs in program order
    task automatic load_expected();
        exp_tab[0]  = '{addr: 5'd1, data: 32'd7};
        exp_tab[1]  = '{addr: 5'd2, data: 32'hffff_fffd};
        exp_tab[2]  = '{addr: 5'd3, data: 32'd4};
        exp_tab[3]  = '{addr: 5'd4, data: 32'd10};
        exp_tab[4]  = '{addr: 5'd5, data: 32'd5};
        exp_tab[5]  = '{addr: 5'd6, data: 32'hffff_ffff};
        exp_tab[6]  = '{addr: 5'd7, data: 32'd1};
        exp_tab[7]  = '{addr: 5'd8, data: 32'd0};
        exp_tab[8]  = '{addr: 5'd9, data: 32'd5};
        exp_tab[9]  = '{addr: 5'd10, data: 32'd10};
        exp_tab[10] = '{addr: 5'd11, data: 32'd15};
        exp_tab[11] = '{addr: 5'd12, data: 32'd5};
        exp_tab[12] = '{addr: 5'd13, data: 32'd64};
        exp_tab[13] = '{addr: 5'd14, data: 32'd15};
        exp_tab[14] = '{addr: 5'd15, data: 32'd22};
        exp_tab[15] = '{addr: 5'd16, data: 32'd10};
        exp_tab[16] = '{addr: 5'd17, data: 32'd1};
        exp_tab[17] = '{addr: 5'd18, data: 32'd11};
        exp_tab[18] = '{addr: 5'd19, data: 32'd19};
        exp_tab[19] = '{addr: 5'd20, data: 32'd20};
        exp_tab[20] = '{addr: 5'd23, data: 32'd23};
        exp_tab[21] = '{addr: 5'd25, data: 32'd25};
        exp_tab[22] = '{addr: 5'd26, data: 32'd7};
    endtask

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_imem_addr(input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t imem_addr got %08h expected %08h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_wb_addr(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t wb.addr got %0d expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_wb_data(input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t wb.data got %08h expected %08h", $time, got, exp);
            stop_on_error();
        end
    endtask

    initial
    begin
        SYS_reset = 1'b1;
        row = 0;
        load_program();
        load_expected();
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        @(negedge SYS_clk);
        check_imem_addr(imem_addr, RESET_PC);    // fetch starts at the reset vector

        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(negedge SYS_clk);
            if (wb.we === 1'b1)
            begin
                if (row >= NUM_EXP)
                begin
                    $display("unexpected write of %08h to register %0d past the last row",
                             wb.data, wb.addr);
                    stop_on_error();
                end
                else
                begin
                    check_wb_addr(wb.addr, exp_tab[row].addr);
                    check_wb_data(wb.data, exp_tab[row].data);
                    row = row + 1;
                end
            end
        end

        if (row != NUM_EXP)
        begin
            $display("timeout after %0d cycles with %0d of %0d expected writes seen",
                     cycle_count, row, NUM_EXP);
            stop_on_error();
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
